//--- Makefile
# verilator flow for the esaxi bridge
TOP = tb_esaxi

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f esaxi.f --top-module esaxi

sim:
	verilator --binary --timing -f esaxi.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- esaxi.f
rtl/esaxi_pkg.sv
rtl/wr_beat_if.sv
rtl/esaxi_write_ctrl.sv
rtl/esaxi_write_pack.sv
rtl/esaxi_read_ctrl.sv
rtl/esaxi_read_return.sv
rtl/esaxi.sv
tb/tb_esaxi.sv

//--- rtl/esaxi.sv
`timescale 1ns/1ps

module esaxi (
   input  logic                  s_axi_aclk,
   input  logic                  s_axi_aresetn,
   // aw channel
   input  esaxi_pkg::axi_id_t    s_axi_awid,
   input  esaxi_pkg::addr_t      s_axi_awaddr,
   input  logic [1:0]            s_axi_awburst,
   input  esaxi_pkg::axi_size_t  s_axi_awsize,
   input  logic                  s_axi_awvalid,
   output logic                  s_axi_awready,
   // w channel
   input  esaxi_pkg::data_t      s_axi_wdata,
   input  esaxi_pkg::strb_t      s_axi_wstrb,
   input  logic                  s_axi_wlast,
   input  logic                  s_axi_wvalid,
   output logic                  s_axi_wready,
   // b channel
   output esaxi_pkg::axi_id_t    s_axi_bid,
   output esaxi_pkg::axi_resp_t  s_axi_bresp,
   output logic                  s_axi_bvalid,
   input  logic                  s_axi_bready,
   // ar channel
   input  esaxi_pkg::axi_id_t    s_axi_arid,
   input  esaxi_pkg::addr_t      s_axi_araddr,
   input  logic [1:0]            s_axi_arburst,
   input  esaxi_pkg::axi_len_t   s_axi_arlen,
   input  esaxi_pkg::axi_size_t  s_axi_arsize,
   input  logic                  s_axi_arvalid,
   output logic                  s_axi_arready,
   // r channel
   output esaxi_pkg::axi_id_t    s_axi_rid,
   output esaxi_pkg::data_t      s_axi_rdata,
   output esaxi_pkg::axi_resp_t  s_axi_rresp,
   output logic                  s_axi_rlast,
   output logic                  s_axi_rvalid,
   input  logic                  s_axi_rready,
   // mesh side
   output logic                  wr_access,
   output esaxi_pkg::packet_t    wr_packet,
   input  logic                  wr_wait,
   output logic                  rd_access,
   output esaxi_pkg::packet_t    rd_packet,
   input  logic                  rr_access,
   input  esaxi_pkg::packet_t    rr_packet
);
   import esaxi_pkg::*;

   logic      ar_start;   // ar handshake pulse
   logic      r_beat;     // r handshake pulse
   axi_size_t rd_size;    // arsize of the current read

   wr_beat_if wr_beat ();

   // ##############################
   // write path, handshake then packing
   // ##############################
   esaxi_write_ctrl write_ctrl0 (.*, .beat_out (wr_beat));
   esaxi_write_pack write_pack0 (.*, .beat_in (wr_beat));

   // ##############################
   // read path, request then return
   // ##############################
   esaxi_read_ctrl   read_ctrl0   (.*);
   esaxi_read_return read_return0 (.*, .r_last (s_axi_rlast));

endmodule

//--- rtl/esaxi_pkg.sv
package esaxi_pkg;

   // ##############################
   // widths
   // ##############################
   localparam int AXI_ID_W = 12;
   localparam int PACKET_W = 99;         // write, datamode, dstaddr, data, srcaddr

   typedef logic [31:0]         addr_t;
   typedef logic [31:0]         data_t;
   typedef logic [3:0]          strb_t;
   typedef logic [AXI_ID_W-1:0] axi_id_t;
   typedef logic [2:0]          axi_size_t;
   typedef logic [7:0]          axi_len_t;   // beats minus one
   typedef logic [1:0]          axi_resp_t;
   typedef logic [1:0]          datamode_t;  // 0 byte, 1 half, 2 word
   typedef logic [PACKET_W-1:0] packet_t;

   localparam int PKT_DATA_LSB = 32;     // data field sits just above srcaddr

   // ##############################
   // axi codes
   // ##############################
   localparam logic [1:0] BURST_INCR  = 2'b01;  // fixed and wrap keep the address
   localparam axi_resp_t  RESP_OKAY   = 2'b00;
   localparam axi_resp_t  RESP_SLVERR = 2'b10;

   // read side
   localparam addr_t RETURN_ADDR  = 32'h0000_0810;
   localparam int    TIMEOUT_W    = 6;   // about 64 cycles of patience
   localparam data_t TIMEOUT_DATA = 32'hdeadbeef;

   typedef enum logic [1:0] {TO_IDLE, TO_ARMED, TO_EXPIRED} timeout_state_t;

endpackage

//--- rtl/esaxi_read_ctrl.sv
`timescale 1ns/1ps

module esaxi_read_ctrl (
   input  logic                  s_axi_aclk,
   input  logic                  s_axi_aresetn,
   input  esaxi_pkg::axi_id_t    s_axi_arid,
   input  esaxi_pkg::addr_t      s_axi_araddr,
   input  logic [1:0]            s_axi_arburst,
   input  esaxi_pkg::axi_len_t   s_axi_arlen,
   input  esaxi_pkg::axi_size_t  s_axi_arsize,
   input  logic                  s_axi_arvalid,
   output logic                  s_axi_arready,
   output esaxi_pkg::axi_id_t    s_axi_rid,
   output logic                  s_axi_rlast,
   input  logic                  r_beat,
   output logic                  ar_start,
   output esaxi_pkg::axi_size_t  rd_size,
   output logic                  rd_access,
   output esaxi_pkg::packet_t    rd_packet
);
   import esaxi_pkg::*;

   logic       read_active;
   logic       req_pend;     // request goes out next cycle
   logic       last_r;       // final r handshake
   addr_t      ar_addr;
   axi_len_t   ar_len;       // beats left minus one
   logic [1:0] ar_burst;

   assign ar_start = s_axi_arvalid & s_axi_arready;
   assign last_r   = r_beat & s_axi_rlast;

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_arready <= 1'b1;
         read_active   <= 1'b0;
         s_axi_rlast   <= 1'b0;
         req_pend      <= 1'b0;
         rd_access     <= 1'b0;
      end
      else
      begin
         req_pend  <= ar_start | (r_beat & ~s_axi_rlast);   // first beat, then each next one
         rd_access <= req_pend;

         if (ar_start)
            s_axi_arready <= 1'b0;   // single outstanding read
         else if (last_r)
            s_axi_arready <= 1'b1;

         if (ar_start)
            read_active <= 1'b1;
         else if (last_r)
            read_active <= 1'b0;

         if (ar_start)
            s_axi_rlast <= (s_axi_arlen == 8'd0);
         else if (r_beat)
            s_axi_rlast <= (ar_len == 8'd1);
      end
   end

   // burst capture, beat count, address step
   always_ff @(posedge s_axi_aclk)
   begin
      if (ar_start)
      begin
         s_axi_rid <= s_axi_arid;
         ar_addr   <= s_axi_araddr;
         ar_len    <= s_axi_arlen;
         ar_burst  <= s_axi_arburst;
         rd_size   <= s_axi_arsize;
      end
      else if (r_beat && read_active)
      begin
         ar_len <= ar_len - 8'd1;
         if (ar_burst == BURST_INCR)
            ar_addr <= {ar_addr[31:2] + 30'd1, 2'b00};
      end
   end

   // read request, data field unused
   always_ff @(posedge s_axi_aclk)
   begin
      if (req_pend)
         rd_packet <= {1'b0, rd_size[1:0], ar_addr, 32'h0, RETURN_ADDR};
   end

endmodule

//--- rtl/esaxi_read_return.sv
`timescale 1ns/1ps

module esaxi_read_return (
   input  logic                  s_axi_aclk,
   input  logic                  s_axi_aresetn,
   input  logic                  s_axi_rready,
   output esaxi_pkg::data_t      s_axi_rdata,
   output esaxi_pkg::axi_resp_t  s_axi_rresp,
   output logic                  s_axi_rvalid,
   input  logic                  rr_access,
   input  esaxi_pkg::packet_t    rr_packet,
   input  logic                  ar_start,
   input  esaxi_pkg::axi_size_t  rd_size,
   input  logic                  r_last,
   output logic                  r_beat
);
   import esaxi_pkg::*;

   timeout_state_t       to_state;
   logic [TIMEOUT_W-1:0] to_count;
   logic                 rr_hit;    // response while waiting for one
   logic                 to_hit;    // gave up waiting
   data_t                rr_data;

   assign r_beat  = s_axi_rvalid & s_axi_rready;
   assign rr_hit  = rr_access & (to_state == TO_ARMED);   // late responses dropped
   assign to_hit  = (to_state == TO_EXPIRED);
   assign rr_data = rr_packet[PKT_DATA_LSB +: 32];

   // ##############################
   // timeout fsm
   // ##############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         to_state <= TO_IDLE;
         to_count <= '1;
      end
      else
      begin
         case (to_state)
            TO_IDLE:
            begin
               to_count <= '1;   // reload
               if (ar_start || (r_beat && !r_last))
                  to_state <= TO_ARMED;
            end
            TO_ARMED:
            begin
               to_count <= to_count - 1'b1;
               if (rr_access)
                  to_state <= TO_IDLE;
               else if (to_count == '0)
                  to_state <= TO_EXPIRED;
            end
            default:
               to_state <= TO_IDLE;   // expired lasts one cycle
         endcase
      end
   end

   // r valid, held until rready
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         s_axi_rvalid <= 1'b0;
      else if (rr_hit || to_hit)
         s_axi_rvalid <= 1'b1;
      else if (r_beat)
         s_axi_rvalid <= 1'b0;
   end

   // r payload, narrow data copied across the bus
   always_ff @(posedge s_axi_aclk)
   begin
      if (to_hit)
      begin
         s_axi_rdata <= TIMEOUT_DATA;
         s_axi_rresp <= RESP_SLVERR;
      end
      else if (rr_hit)
      begin
         s_axi_rresp <= RESP_OKAY;
         case (rd_size[1:0])
            2'b00:   s_axi_rdata <= {4{rr_data[7:0]}};    // byte
            2'b01:   s_axi_rdata <= {2{rr_data[15:0]}};   // half
            default: s_axi_rdata <= rr_data;
         endcase
      end
   end

endmodule

//--- rtl/esaxi_write_ctrl.sv
`timescale 1ns/1ps

module esaxi_write_ctrl (
   input  logic                  s_axi_aclk,
   input  logic                  s_axi_aresetn,
   input  esaxi_pkg::axi_id_t    s_axi_awid,
   input  esaxi_pkg::addr_t      s_axi_awaddr,
   input  logic [1:0]            s_axi_awburst,
   input  esaxi_pkg::axi_size_t  s_axi_awsize,
   input  logic                  s_axi_awvalid,
   output logic                  s_axi_awready,
   input  esaxi_pkg::data_t      s_axi_wdata,
   input  esaxi_pkg::strb_t      s_axi_wstrb,
   input  logic                  s_axi_wlast,
   input  logic                  s_axi_wvalid,
   output logic                  s_axi_wready,
   output esaxi_pkg::axi_id_t    s_axi_bid,
   output esaxi_pkg::axi_resp_t  s_axi_bresp,
   output logic                  s_axi_bvalid,
   input  logic                  s_axi_bready,
   input  logic                  wr_wait,
   wr_beat_if.ctrl               beat_out
);
   import esaxi_pkg::*;

   logic       aw_hs;          // address accepted
   logic       w_hs;           // data beat accepted
   logic       last_beat;
   logic       write_active;   // from aw handshake to last beat
   addr_t      aw_addr;        // running beat address
   axi_size_t  aw_size;
   logic [1:0] aw_burst;

   assign aw_hs     = s_axi_awvalid & s_axi_awready;
   assign w_hs      = s_axi_wvalid & s_axi_wready;
   assign last_beat = w_hs & s_axi_wlast;

   assign s_axi_bresp = RESP_OKAY;   // writes never fail here

   // ##############################
   // handshakes
   // ##############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_awready <= 1'b1;
         s_axi_wready  <= 1'b0;
         s_axi_bvalid  <= 1'b0;
         write_active  <= 1'b0;
      end
      else
      begin
         // one write at a time, reopen after b is taken
         if (aw_hs)
            s_axi_awready <= 1'b0;
         else if (s_axi_bvalid && s_axi_bready)
            s_axi_awready <= 1'b1;

         if (aw_hs)
            write_active <= 1'b1;
         else if (last_beat)
            write_active <= 1'b0;

         if (last_beat)
            s_axi_wready <= 1'b0;
         else
            s_axi_wready <= write_active & ~wr_wait;   // mesh stall, one cycle late

         if (last_beat)
            s_axi_bvalid <= 1'b1;
         else if (s_axi_bready)
            s_axi_bvalid <= 1'b0;   // held until taken
      end
   end

   // burst capture and address counter
   always_ff @(posedge s_axi_aclk)
   begin
      if (aw_hs)
      begin
         s_axi_bid <= s_axi_awid;
         aw_addr   <= s_axi_awaddr;
         aw_size   <= s_axi_awsize;
         aw_burst  <= s_axi_awburst;
      end
      else if (w_hs && aw_burst == BURST_INCR)
         aw_addr <= {aw_addr[31:2] + 30'd1, 2'b00};   // next word, lanes from strobes
   end

   // beat out to the packer
   assign beat_out.beat = w_hs;
   assign beat_out.addr = aw_addr;
   assign beat_out.size = aw_size;
   assign beat_out.data = s_axi_wdata;
   assign beat_out.strb = s_axi_wstrb;

endmodule

//--- rtl/esaxi_write_pack.sv
`timescale 1ns/1ps

module esaxi_write_pack (
   input  logic                s_axi_aclk,
   input  logic                s_axi_aresetn,
   wr_beat_if.pack             beat_in,
   output logic                wr_access,
   output esaxi_pkg::packet_t  wr_packet
);
   import esaxi_pkg::*;

   logic [1:0] lane;       // lowest strobed byte
   logic       s1_valid;
   data_t      s1_data;    // data moved down to lane 0
   addr_t      s1_addr;
   datamode_t  s1_mode;

   always_comb
   begin
      if (beat_in.strb[0])
         lane = 2'd0;
      else if (beat_in.strb[1])
         lane = 2'd1;
      else if (beat_in.strb[2])
         lane = 2'd2;
      else
         lane = 2'd3;   // also the no-strobe case
   end

   // pulse rides along both stages
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s1_valid  <= 1'b0;
         wr_access <= 1'b0;
      end
      else
      begin
         s1_valid  <= beat_in.beat;
         wr_access <= s1_valid;
      end
   end

   // stage 1, alignment
   always_ff @(posedge s_axi_aclk)
   begin
      if (beat_in.beat)
      begin
         s1_data <= beat_in.data >> {lane, 3'b000};   // zero fill from the top
         s1_addr <= {beat_in.addr[31:2], lane};
         s1_mode <= beat_in.size[1:0];
      end
   end

   // stage 2, packet
   always_ff @(posedge s_axi_aclk)
   begin
      if (s1_valid)
         wr_packet <= {1'b1, s1_mode, s1_addr, s1_data, 32'h0};   // no srcaddr on writes
   end

endmodule

//--- rtl/wr_beat_if.sv
`timescale 1ns/1ps

// accepted w beats, handshake to packer
interface wr_beat_if;
   import esaxi_pkg::*;

   logic      beat;   // one cycle per w handshake
   addr_t     addr;   // address of this beat
   axi_size_t size;   // awsize of the burst
   data_t     data;
   strb_t     strb;

   // no back-pressure, packer must take every beat
   modport ctrl (output beat, output addr, output size, output data, output strb);
   modport pack (input beat, input addr, input size, input data, input strb);

endinterface

//--- tb/esaxi_stimulus.txt
# op name addr len size burst strb wdata delay rdata exp_addr exp_data exp_resp
# W checks wr_packet and B, R checks rd_packet dstaddr and R beats, delay -1 means no reply
W wr_half_lane2   80000100 0 1 1 c aabbccdd  0 00000000 80000102 0000aabb 0
W wr_byte_lane3   80000204 0 0 1 8 11223344  0 00000000 80000207 00000011 0
W wr_half_lane1   80000400 0 1 1 6 deadface  0 00000000 80000401 00deadfa 0
W wr_word         80000300 0 2 1 f 01020304  0 00000000 80000300 01020304 0
W wr_incr4_word   80001000 3 2 1 f cafef00d  0 00000000 80001000 cafef00d 0
W wr_incr2_byte   80002000 1 0 1 2 12345678  0 00000000 80002001 00123456 0
W wr_fixed3       80003008 2 2 0 f 0badcafe  0 00000000 80003008 0badcafe 0
W wr_wrap_as_fix  80003010 1 1 2 3 55667788  0 00000000 80003010 55667788 0
R rd_word         80004000 0 2 1 0 00000000  3 89abcdef 80004000 89abcdef 0
R rd_incr4_byte   80004001 3 0 1 0 00000000  1 123456a5 80004001 a5a5a5a5 0
R rd_fixed_half   80004102 1 1 0 0 00000000  0 0000beef 80004102 beefbeef 0
R rd_timeout      80005000 0 2 1 0 00000000 -1 00000000 80005000 deadbeef 2
R rd_after_to     80005004 1 2 1 0 00000000  5 13579bdf 80005004 13579bdf 0
R rd_incr3_half   80006002 2 1 1 0 00000000  2 12345678 80006002 56785678 0

//--- tb/tb_esaxi.sv
`timescale 1ns/1ps

module tb_esaxi;
   localparam int LIMIT = 200;   // cycles allowed per wait

   logic        s_axi_aclk = 1'b0;
   logic        s_axi_aresetn;
   logic [11:0] s_axi_awid, s_axi_bid, s_axi_arid, s_axi_rid;
   logic [31:0] s_axi_awaddr, s_axi_wdata, s_axi_araddr, s_axi_rdata;
   logic [1:0]  s_axi_awburst, s_axi_arburst, s_axi_bresp, s_axi_rresp;
   logic [2:0]  s_axi_awsize, s_axi_arsize;
   logic [3:0]  s_axi_wstrb;
   logic [7:0]  s_axi_arlen;
   logic        s_axi_awvalid, s_axi_awready, s_axi_wlast, s_axi_wvalid, s_axi_wready;
   logic        s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
   logic        s_axi_rlast, s_axi_rvalid, s_axi_rready;
   logic        wr_access, rd_access, rr_access;
   logic        wr_wait = 1'b0;
   logic [98:0] wr_packet, rd_packet, rr_packet;

   int unsigned     rng_state = 25;
   int              checks, errors, timeouts, cycle;
   bit              timed_out;
   int              resp_delay;       // mesh reply delay in cycles or -1 for silence
   logic [31:0]     resp_data;
   logic [98:0]     wr_pkts[$];
   logic [98:0]     rd_pkts[$];
   int              hs_cycles[$];     // cycle of each accepted w beat
   // one stimulus row
   logic [8*32-1:0] op, name;
   logic [31:0]     addr, wdata, rdata, exp_addr, exp_data;
   logic [3:0]      strb;
   int              len, size, burst, delay, exp_resp;

   esaxi dut0 (.*);

   always #10 s_axi_aclk = ~s_axi_aclk;

   function automatic int unsigned next_random();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state >> 16;
   endfunction

   task automatic check_value(input string what, input logic [98:0] expected,
                              input logic [98:0] actual);
      checks++;
      if (expected !== actual)
      begin
         errors++;
         $display("mismatch %0s %0s: expected %h actual %h", name, what, expected, actual);
      end
   endtask

   // handshake signals as seen at this edge
   function automatic logic sampled(input string what);
      case (what)
         "awready": return s_axi_awready;
         "wready":  return s_axi_wready;
         "bvalid":  return s_axi_bvalid;
         "arready": return s_axi_arready;
         default:   return s_axi_rvalid;
      endcase
   endfunction

   task automatic wait_for(input string what);
      int t;
      t = 0;
      do
      begin
         @(posedge s_axi_aclk);
         t++;
      end
      while (!sampled(what) && t < LIMIT);
      if (!sampled(what))
      begin
         $display("timeout: %0s never came in test %0s", what, name);
         timeouts++;
         timed_out = 1'b1;
      end
   endtask

   // ##############################
   // mesh side
   // ##############################
   always @(posedge s_axi_aclk)
      wr_wait <= (next_random() % 4) == 0;   // stall about one cycle in four

   // w beats in and write packets out
   always @(posedge s_axi_aclk)
   begin
      cycle = cycle + 1;
      if (s_axi_wvalid && s_axi_wready)
         hs_cycles.push_back(cycle);
      if (wr_access)
      begin
         wr_pkts.push_back(wr_packet);
         if (hs_cycles.size() == 0)
         begin
            $display("wr_access came with no accepted write beat in test %0s", name);
            errors++;
         end
         else
            check_value("wr_access delay", 2, cycle - hs_cycles.pop_front());
      end
   end

   // read responder
   initial
   begin
      rr_access = 1'b0;
      rr_packet = '0;
      forever
      begin
         @(posedge s_axi_aclk);
         if (rd_access)
         begin
            rd_pkts.push_back(rd_packet);
            if (resp_delay >= 0)
            begin
               repeat (resp_delay) @(posedge s_axi_aclk);
               rr_access <= 1'b1;
               rr_packet <= {3'b000, 32'h0, resp_data, 32'h0};   // data field only
               @(posedge s_axi_aclk);
               rr_access <= 1'b0;
            end
         end
      end
   end

   // ##############################
   // axi master
   // ##############################
   task automatic write_burst();
      int i;
      int t;
      int stall;
      logic [11:0] id;
      logic [31:0] a;
      id = 12'(next_random() % 4096);
      s_axi_awid    <= id;
      s_axi_awaddr  <= addr;
      s_axi_awburst <= burst[1:0];
      s_axi_awsize  <= size[2:0];
      s_axi_awvalid <= 1'b1;
      wait_for("awready");
      s_axi_awvalid <= 1'b0;
      if (timed_out)
         return;
      for (i = 0; i <= len; i++)
      begin
         s_axi_wdata  <= wdata;
         s_axi_wstrb  <= strb;
         s_axi_wlast  <= (i == len);
         s_axi_wvalid <= 1'b1;
         wait_for("wready");
         if (timed_out)
            return;
      end
      s_axi_wvalid <= 1'b0;
      s_axi_wlast  <= 1'b0;
      wait_for("bvalid");
      if (timed_out)
         return;
      check_value("bid", id, s_axi_bid);
      check_value("bresp", exp_resp, s_axi_bresp);
      stall = 1 + next_random() % 3;
      repeat (stall)
      begin
         @(posedge s_axi_aclk);
         check_value("bvalid held", 1, s_axi_bvalid);
      end
      s_axi_bready <= 1'b1;
      @(posedge s_axi_aclk);
      s_axi_bready <= 1'b0;
      t = 0;
      while (wr_pkts.size() < len + 1 && t < LIMIT)
      begin
         @(posedge s_axi_aclk);
         t++;
      end
      if (wr_pkts.size() < len + 1)
      begin
         $display("timeout: write packets missing in test %0s", name);
         timeouts++;
      end
      check_value("wr_access count", len + 1, wr_pkts.size());
      for (i = 0; i <= len && wr_pkts.size() > 0; i++)
      begin
         // incr moves the word and the lane bits stay from the strobes
         a = (burst == 1) ? (((exp_addr & ~32'h3) + 4 * i) | (exp_addr & 32'h3)) : exp_addr;
         check_value($sformatf("wr_packet beat %0d", i),
                     {1'b1, size[1:0], a, exp_data, 32'h0}, wr_pkts.pop_front());
      end
   endtask

   task automatic read_burst();
      int i;
      int stall;
      logic [11:0] id;
      logic [31:0] a;
      id = 12'(next_random() % 4096);
      resp_delay = delay;
      resp_data  = rdata;
      rd_pkts.delete();
      s_axi_arid    <= id;
      s_axi_araddr  <= addr;
      s_axi_arburst <= burst[1:0];
      s_axi_arlen   <= len[7:0];
      s_axi_arsize  <= size[2:0];
      s_axi_arvalid <= 1'b1;
      wait_for("arready");
      s_axi_arvalid <= 1'b0;
      if (timed_out)
         return;
      for (i = 0; i <= len; i++)
      begin
         wait_for("rvalid");
         if (timed_out)
            return;
         check_value("rdata", exp_data, s_axi_rdata);
         check_value("rresp", exp_resp, s_axi_rresp);
         check_value("rlast", i == len, s_axi_rlast);
         check_value("rid", id, s_axi_rid);
         stall = next_random() % 3;
         repeat (stall) @(posedge s_axi_aclk);   // rready stall
         s_axi_rready <= 1'b1;
         @(posedge s_axi_aclk);
         s_axi_rready <= 1'b0;
      end
      check_value("rd_access count", len + 1, rd_pkts.size());
      for (i = 0; i <= len && rd_pkts.size() > 0; i++)
      begin
         a = (burst == 1 && i > 0) ? ((exp_addr & ~32'h3) + 4 * i) : exp_addr;
         check_value($sformatf("rd_packet beat %0d", i),
                     {1'b0, size[1:0], a, 32'h0, 32'h0000_0810}, rd_pkts.pop_front());
      end
   endtask

   // ##############################
   // main sequence
   // ##############################
   initial
   begin
      int fd;
      int code;
      logic [8*160-1:0] rest;
      s_axi_aresetn = 1'b0;
      {s_axi_awid, s_axi_awaddr, s_axi_awburst, s_axi_awsize, s_axi_awvalid} = '0;
      {s_axi_wdata, s_axi_wstrb, s_axi_wlast, s_axi_wvalid, s_axi_bready} = '0;
      {s_axi_arid, s_axi_araddr, s_axi_arburst, s_axi_arlen, s_axi_arsize} = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      name = "reset";
      repeat (16) @(posedge s_axi_aclk);
      s_axi_aresetn <= 1'b1;
      @(posedge s_axi_aclk);
      check_value("awready", 1, s_axi_awready);
      check_value("arready", 1, s_axi_arready);
      check_value("idle outputs", 0, {s_axi_wready, s_axi_bvalid, s_axi_rvalid, wr_access,
                                      rd_access});
      fd = $fopen("tb/esaxi_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("could not open tb/esaxi_stimulus.txt");
         errors++;
      end
      else
      begin
         while (!timed_out && $fscanf(fd, "%s", op) == 1)
         begin
            if (op == "#")
               code = $fgets(rest, fd);   // column notes
            else
            begin
               code = $fscanf(fd, "%s %h %d %d %d %h %h %d %h %h %h %d", name, addr, len,
                              size, burst, strb, wdata, delay, rdata, exp_addr, exp_data,
                              exp_resp);
               if (code != 12)
               begin
                  $display("stimulus row after %0s is incomplete", name);
                  errors++;
               end
               else if (op == "W")
                  write_burst();
               else
                  read_burst();
            end
         end
         $fclose(fd);
      end
      $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
      if (errors + timeouts == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule
